// File: hw/axi_pkg.sv
package axi_pkg;

	// Master-side transaction ID.
	typedef logic [3:0] axi_id_t;

	// Slave-side ID, master number above the master ID.
	typedef logic [7:0] axi_ids_t;

	typedef logic [31:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;

	// Burst length minus one.
	typedef logic [3:0] axi_len_t;

	typedef logic [2:0] axi_size_t;
	typedef logic [1:0] axi_burst_t;
	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_DECERR = 2'b11; // No slave at this address.

endpackage

// File: hw/xbar_pkg.sv
package xbar_pkg;

	typedef enum logic {
		MST0 = 1'b0,
		MST1 = 1'b1
	} master_e;

	typedef enum logic [1:0] {
		SLV0    = 2'd0,
		SLV1    = 2'd1,
		SLV_DEF = 2'd2 // Decode-error slave.
	} slave_e;

	// Address states hold an AR request, data states wait for the last R beat.
	typedef enum logic [1:0] {
		M0_ADDR = 2'd0,
		M1_ADDR = 2'd1,
		M0_DATA = 2'd2,
		M1_DATA = 2'd3
	} rd_state_e;

	// Upper sixteen address bits.
	typedef logic [15:0] region_t;

	localparam region_t REGION_S0 = 16'h0000;
	localparam region_t REGION_S1 = 16'h0001;

endpackage

// File: hw/axi_ar_if.sv
`timescale 1ns/1ps

interface axi_ar_if
	import axi_pkg::*;
();

	axi_ids_t   id;    // Master ID zero-extended on the master side.
	axi_addr_t  addr;
	axi_len_t   len;
	axi_size_t  size;
	axi_burst_t burst;
	logic       valid;
	logic       ready;

	modport master (
		output id,
		output addr,
		output len,
		output size,
		output burst,
		output valid,
		input  ready
	);

	modport slave (
		input  id,
		input  addr,
		input  len,
		input  size,
		input  burst,
		input  valid,
		output ready
	);

endinterface

// File: hw/axi_r_if.sv
`timescale 1ns/1ps

interface axi_r_if
	import axi_pkg::*;
();

	axi_ids_t  id;
	axi_data_t data;
	axi_resp_t resp;
	logic      last;
	logic      valid;
	logic      ready;

	// Master modport is the side that returns the data.
	modport master (
		output id,
		output data,
		output resp,
		output last,
		output valid,
		input  ready
	);

	modport slave (
		input  id,
		input  data,
		input  resp,
		input  last,
		input  valid,
		output ready
	);

endinterface

// File: hw/ar_arbiter.sv
`timescale 1ns/1ps

module ar_arbiter
	import axi_pkg::*, xbar_pkg::*;
#(
	parameter region_t S0_REGION = REGION_S0,
	parameter region_t S1_REGION = REGION_S1
) (
	input  logic     ACLK,
	input  logic     ARESETn,
	axi_ar_if.slave  ar_m0,
	axi_ar_if.slave  ar_m1,
	axi_ar_if.master ar_s0,
	axi_ar_if.master ar_s1,
	axi_ar_if.master ar_def,
	input  logic     burst_done,
	output master_e  owner,
	output slave_e   target,
	output logic     data_phase
);

	rd_state_e  state;
	rd_state_e  next_state;
	master_e    sel;
	logic       req_valid;
	axi_ids_t   req_mid;
	axi_ids_t   req_id;
	axi_addr_t  req_addr;
	axi_len_t   req_len;
	axi_size_t  req_size;
	axi_burst_t req_burst;
	slave_e     dec;
	logic       slv_ready;
	logic       handshake;

	// Pick the master whose request is presented this cycle.
	always_comb begin
		sel       = owner;
		req_valid = 1'b0;
		case (state)
			M0_ADDR: begin
				if (ar_m0.valid) begin
					sel       = MST0; // Master 0 wins in idle.
					req_valid = 1'b1;
				end else if (ar_m1.valid) begin
					sel       = MST1;
					req_valid = 1'b1;
				end
			end
			M1_ADDR: begin
				sel       = MST1; // Locked until the handshake.
				req_valid = ar_m1.valid;
			end
			default: begin
				sel       = owner;
				req_valid = 1'b0;
			end
		endcase
	end

	always_comb begin
		if (sel == MST0) begin
			req_mid   = ar_m0.id;
			req_addr  = ar_m0.addr;
			req_len   = ar_m0.len;
			req_size  = ar_m0.size;
			req_burst = ar_m0.burst;
		end else begin
			req_mid   = ar_m1.id;
			req_addr  = ar_m1.addr;
			req_len   = ar_m1.len;
			req_size  = ar_m1.size;
			req_burst = ar_m1.burst;
		end
	end

	assign req_id = {axi_id_t'(sel), axi_id_t'(req_mid)}; // Master number on top.

	always_comb begin
		if (req_addr[31:16] == S0_REGION)
			dec = SLV0;
		else if (req_addr[31:16] == S1_REGION)
			dec = SLV1;
		else
			dec = SLV_DEF;
	end

	always_comb begin
		case (dec)
			SLV0:    slv_ready = ar_s0.ready;
			SLV1:    slv_ready = ar_s1.ready;
			default: slv_ready = ar_def.ready;
		endcase
	end

	assign handshake = req_valid && slv_ready;

	// Payload goes to every slave, only the decoded one sees valid.
	assign ar_s0.id     = req_id;
	assign ar_s0.addr   = req_addr;
	assign ar_s0.len    = req_len;
	assign ar_s0.size   = req_size;
	assign ar_s0.burst  = req_burst;
	assign ar_s0.valid  = req_valid && (dec == SLV0);
	assign ar_s1.id     = req_id;
	assign ar_s1.addr   = req_addr;
	assign ar_s1.len    = req_len;
	assign ar_s1.size   = req_size;
	assign ar_s1.burst  = req_burst;
	assign ar_s1.valid  = req_valid && (dec == SLV1);
	assign ar_def.id    = req_id;
	assign ar_def.addr  = req_addr;
	assign ar_def.len   = req_len;
	assign ar_def.size  = req_size;
	assign ar_def.burst = req_burst;
	assign ar_def.valid = req_valid && (dec == SLV_DEF);

	assign ar_m0.ready = req_valid && (sel == MST0) && slv_ready;
	assign ar_m1.ready = req_valid && (sel == MST1) && slv_ready;

	always_comb begin
		next_state = state;
		case (state)
			M0_ADDR: begin
				if (handshake)
					next_state = (sel == MST0) ? M0_DATA : M1_DATA;
				else if (req_valid && sel == MST1)
					next_state = M1_ADDR; // Hold master 1 until accepted.
			end
			M1_ADDR: begin
				if (handshake)
					next_state = M1_DATA;
			end
			M0_DATA: begin
				if (burst_done)
					next_state = (!ar_m0.valid && ar_m1.valid) ? M1_ADDR : M0_ADDR;
			end
			M1_DATA: begin
				if (burst_done)
					next_state = M0_ADDR;
			end
			default: next_state = M0_ADDR;
		endcase
	end

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			state  <= M0_ADDR;
			owner  <= MST0;
			target <= SLV0;
		end else begin
			state <= next_state;
			if (handshake) begin
				owner  <= sel;
				target <= dec;
			end
		end
	end

	assign data_phase = (state == M0_DATA) || (state == M1_DATA);

endmodule

// File: hw/r_router.sv
`timescale 1ns/1ps

module r_router
	import axi_pkg::*, xbar_pkg::*;
(
	axi_r_if.slave  r_s0,
	axi_r_if.slave  r_s1,
	axi_r_if.slave  r_def,
	axi_r_if.master r_m0,
	axi_r_if.master r_m1,
	input  master_e owner,
	input  slave_e  target,
	input  logic    data_phase,
	output logic    burst_done
);

	axi_ids_t  sel_id;
	axi_data_t sel_data;
	axi_resp_t sel_resp;
	logic      sel_last;
	logic      sel_valid;
	logic      own_ready;
	logic      fwd_valid;

	always_comb begin
		case (target)
			SLV0: begin
				sel_id    = r_s0.id;
				sel_data  = r_s0.data;
				sel_resp  = r_s0.resp;
				sel_last  = r_s0.last;
				sel_valid = r_s0.valid;
			end
			SLV1: begin
				sel_id    = r_s1.id;
				sel_data  = r_s1.data;
				sel_resp  = r_s1.resp;
				sel_last  = r_s1.last;
				sel_valid = r_s1.valid;
			end
			default: begin
				sel_id    = r_def.id;
				sel_data  = r_def.data;
				sel_resp  = r_def.resp;
				sel_last  = r_def.last;
				sel_valid = r_def.valid;
			end
		endcase
	end

	assign own_ready = (owner == MST0) ? r_m0.ready : r_m1.ready;
	assign fwd_valid = data_phase && sel_valid;

	// Drop the master number, keep the master's own ID.
	assign r_m0.id    = axi_ids_t'(axi_id_t'(sel_id));
	assign r_m0.data  = sel_data;
	assign r_m0.resp  = sel_resp;
	assign r_m0.last  = sel_last;
	assign r_m0.valid = fwd_valid && (owner == MST0);
	assign r_m1.id    = axi_ids_t'(axi_id_t'(sel_id));
	assign r_m1.data  = sel_data;
	assign r_m1.resp  = sel_resp;
	assign r_m1.last  = sel_last;
	assign r_m1.valid = fwd_valid && (owner == MST1);

	assign r_s0.ready  = data_phase && (target == SLV0) && own_ready;
	assign r_s1.ready  = data_phase && (target == SLV1) && own_ready;
	assign r_def.ready = data_phase && (target == SLV_DEF) && own_ready;

	assign burst_done = fwd_valid && own_ready && sel_last; // Last beat accepted.

endmodule

// File: hw/decerr_slave.sv
`timescale 1ns/1ps

module decerr_slave
	import axi_pkg::*;
(
	input  logic    ACLK,
	input  logic    ARESETn,
	axi_ar_if.slave ar,
	axi_r_if.master r
);

	logic     busy;
	axi_len_t beats_left;
	axi_ids_t id_q;
	logic     ar_hs;
	logic     r_hs;

	assign ar.ready = ar.valid && !busy; // One request at a time.
	assign ar_hs    = ar.valid && ar.ready;
	assign r_hs     = r.valid && r.ready;

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			busy       <= 1'b0;
			beats_left <= '0;
		end else if (ar_hs) begin
			busy       <= 1'b1;
			beats_left <= ar.len;
		end else if (r_hs) begin
			if (beats_left == '0)
				busy <= 1'b0;
			else
				beats_left <= beats_left - 1'b1;
		end
	end

	always_ff @(posedge ACLK) begin
		if (ar_hs)
			id_q <= ar.id;
	end

	assign r.id    = id_q;
	assign r.data  = '0;
	assign r.resp  = RESP_DECERR;
	assign r.last  = (beats_left == '0);
	assign r.valid = busy; // Held until the master takes it.

endmodule

// File: hw/axi_read_xbar.sv
`timescale 1ns/1ps

module axi_read_xbar
	import axi_pkg::*, xbar_pkg::*;
#(
	parameter region_t S0_REGION = REGION_S0,
	parameter region_t S1_REGION = REGION_S1
) (
	input  logic       ACLK,
	input  logic       ARESETn,
	input  axi_id_t    ARID_M0,
	input  axi_addr_t  ARADDR_M0,
	input  axi_len_t   ARLEN_M0,
	input  axi_size_t  ARSIZE_M0,
	input  axi_burst_t ARBURST_M0,
	input  logic       ARVALID_M0,
	output logic       ARREADY_M0,
	output axi_id_t    RID_M0,
	output axi_data_t  RDATA_M0,
	output axi_resp_t  RRESP_M0,
	output logic       RLAST_M0,
	output logic       RVALID_M0,
	input  logic       RREADY_M0,
	input  axi_id_t    ARID_M1,
	input  axi_addr_t  ARADDR_M1,
	input  axi_len_t   ARLEN_M1,
	input  axi_size_t  ARSIZE_M1,
	input  axi_burst_t ARBURST_M1,
	input  logic       ARVALID_M1,
	output logic       ARREADY_M1,
	output axi_id_t    RID_M1,
	output axi_data_t  RDATA_M1,
	output axi_resp_t  RRESP_M1,
	output logic       RLAST_M1,
	output logic       RVALID_M1,
	input  logic       RREADY_M1,
	output axi_ids_t   ARID_S0,
	output axi_addr_t  ARADDR_S0,
	output axi_len_t   ARLEN_S0,
	output axi_size_t  ARSIZE_S0,
	output axi_burst_t ARBURST_S0,
	output logic       ARVALID_S0,
	input  logic       ARREADY_S0,
	input  axi_ids_t   RID_S0,
	input  axi_data_t  RDATA_S0,
	input  axi_resp_t  RRESP_S0,
	input  logic       RLAST_S0,
	input  logic       RVALID_S0,
	output logic       RREADY_S0,
	output axi_ids_t   ARID_S1,
	output axi_addr_t  ARADDR_S1,
	output axi_len_t   ARLEN_S1,
	output axi_size_t  ARSIZE_S1,
	output axi_burst_t ARBURST_S1,
	output logic       ARVALID_S1,
	input  logic       ARREADY_S1,
	input  axi_ids_t   RID_S1,
	input  axi_data_t  RDATA_S1,
	input  axi_resp_t  RRESP_S1,
	input  logic       RLAST_S1,
	input  logic       RVALID_S1,
	output logic       RREADY_S1
);

	axi_ar_if ar_m0 ();
	axi_ar_if ar_m1 ();
	axi_ar_if ar_s0 ();
	axi_ar_if ar_s1 ();
	axi_ar_if ar_def ();
	axi_r_if  r_s0 ();
	axi_r_if  r_s1 ();
	axi_r_if  r_def ();
	axi_r_if  r_m0 ();
	axi_r_if  r_m1 ();

	master_e owner;
	slave_e  target;
	logic    data_phase;
	logic    burst_done;

	// Master AR ports, IDs zero-extended.
	assign ar_m0.id    = axi_ids_t'(ARID_M0);
	assign ar_m0.addr  = ARADDR_M0;
	assign ar_m0.len   = ARLEN_M0;
	assign ar_m0.size  = ARSIZE_M0;
	assign ar_m0.burst = ARBURST_M0;
	assign ar_m0.valid = ARVALID_M0;
	assign ARREADY_M0  = ar_m0.ready;
	assign ar_m1.id    = axi_ids_t'(ARID_M1);
	assign ar_m1.addr  = ARADDR_M1;
	assign ar_m1.len   = ARLEN_M1;
	assign ar_m1.size  = ARSIZE_M1;
	assign ar_m1.burst = ARBURST_M1;
	assign ar_m1.valid = ARVALID_M1;
	assign ARREADY_M1  = ar_m1.ready;

	assign ARID_S0     = ar_s0.id;
	assign ARADDR_S0   = ar_s0.addr;
	assign ARLEN_S0    = ar_s0.len;
	assign ARSIZE_S0   = ar_s0.size;
	assign ARBURST_S0  = ar_s0.burst;
	assign ARVALID_S0  = ar_s0.valid;
	assign ar_s0.ready = ARREADY_S0;
	assign ARID_S1     = ar_s1.id;
	assign ARADDR_S1   = ar_s1.addr;
	assign ARLEN_S1    = ar_s1.len;
	assign ARSIZE_S1   = ar_s1.size;
	assign ARBURST_S1  = ar_s1.burst;
	assign ARVALID_S1  = ar_s1.valid;
	assign ar_s1.ready = ARREADY_S1;

	assign r_s0.id    = RID_S0;
	assign r_s0.data  = RDATA_S0;
	assign r_s0.resp  = RRESP_S0;
	assign r_s0.last  = RLAST_S0;
	assign r_s0.valid = RVALID_S0;
	assign RREADY_S0  = r_s0.ready;
	assign r_s1.id    = RID_S1;
	assign r_s1.data  = RDATA_S1;
	assign r_s1.resp  = RRESP_S1;
	assign r_s1.last  = RLAST_S1;
	assign r_s1.valid = RVALID_S1;
	assign RREADY_S1  = r_s1.ready;

	assign RID_M0     = axi_id_t'(r_m0.id);
	assign RDATA_M0   = r_m0.data;
	assign RRESP_M0   = r_m0.resp;
	assign RLAST_M0   = r_m0.last;
	assign RVALID_M0  = r_m0.valid;
	assign r_m0.ready = RREADY_M0;
	assign RID_M1     = axi_id_t'(r_m1.id);
	assign RDATA_M1   = r_m1.data;
	assign RRESP_M1   = r_m1.resp;
	assign RLAST_M1   = r_m1.last;
	assign RVALID_M1  = r_m1.valid;
	assign r_m1.ready = RREADY_M1;

	ar_arbiter #(
		.S0_REGION (S0_REGION),
		.S1_REGION (S1_REGION)
	) u_ar_arbiter (
		.ACLK       (ACLK),
		.ARESETn    (ARESETn),
		.ar_m0      (ar_m0),
		.ar_m1      (ar_m1),
		.ar_s0      (ar_s0),
		.ar_s1      (ar_s1),
		.ar_def     (ar_def),
		.burst_done (burst_done),
		.owner      (owner),
		.target     (target),
		.data_phase (data_phase)
	);

	r_router u_r_router (
		.r_s0       (r_s0),
		.r_s1       (r_s1),
		.r_def      (r_def),
		.r_m0       (r_m0),
		.r_m1       (r_m1),
		.owner      (owner),
		.target     (target),
		.data_phase (data_phase),
		.burst_done (burst_done)
	);

	decerr_slave u_decerr_slave (
		.ACLK    (ACLK),
		.ARESETn (ARESETn),
		.ar      (ar_def),
		.r       (r_def)
	);

endmodule

// File: tb/tb_axi_read_xbar.sv
`timescale 1ns/1ps

module axi_slave_model #(
	parameter logic [31:0] DATA_XOR = 32'h0
) (
	input  logic        ACLK,
	input  logic [7:0]  arid,
	input  logic [31:0] araddr,
	input  logic [3:0]  arlen,
	input  logic [2:0]  arsize,
	input  logic [1:0]  arburst,
	input  logic        arvalid,
	output logic        arready,
	output logic [7:0]  rid,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rlast,
	output logic        rvalid,
	input  logic        rready
);

	logic [7:0]  last_id;          // Taken at the last AR handshake.
	logic [31:0] last_addr;
	logic [2:0]  last_size;
	logic [1:0]  last_burst;
	int          valid_cycles = 0; // Cycles with ARVALID high.
	logic [31:0] addr_q;
	logic [3:0]  len_q;
	int          beat;
	logic        busy;
	logic        ar_hs;
	logic        r_hs;
	logic        ar_seen;

	initial begin
		arready    = 1'b0;
		rid        = 8'h0;
		rdata      = 32'h0;
		rresp      = 2'b00;
		rlast      = 1'b0;
		rvalid     = 1'b0;
		busy       = 1'b0;
		beat       = 0;
		last_id    = 8'h0;
		last_addr  = 32'h0;
		last_size  = 3'h0;
		last_burst = 2'h0;
		addr_q     = 32'h0;
		len_q      = 4'h0;
		forever begin
			@(posedge ACLK);
			ar_hs   = arvalid && arready;
			r_hs    = rvalid && rready;
			ar_seen = arvalid;
			if (arvalid)
				valid_cycles++;
			if (ar_hs) begin
				last_id    = arid;
				last_addr  = araddr;
				last_size  = arsize;
				last_burst = arburst;
				addr_q     = araddr;
				len_q      = arlen;
			end
			@(negedge ACLK);
			if (ar_hs) begin
				arready = 1'b0;
				busy    = 1'b1;
				beat    = 0;
				rid     = last_id;
				rvalid  = 1'b1;
			end else if (r_hs) begin
				if (rlast) begin
					busy   = 1'b0;
					rvalid = 1'b0;
				end else
					beat++;
			end else if (ar_seen && !busy)
				arready = 1'b1; // One cycle after ARVALID.
			rdata = (addr_q + 32'(4 * beat)) ^ DATA_XOR;
			rlast = rvalid && (beat == int'(len_q));
		end
	end

endmodule

module tb_axi_read_xbar;

	localparam int          CLK_PERIOD = 8;
	localparam int          WAIT_LIMIT = 64;
	localparam int          NUM_READS  = 25;
	localparam int          WATCHDOG_CYCLES = NUM_READS * WAIT_LIMIT * 18 + 100;
	localparam logic [15:0] MAP_S0     = 16'h0000;
	localparam logic [15:0] MAP_S1     = 16'h0001;
	localparam logic [31:0] XOR_S0     = 32'h5a5a_0000;
	localparam logic [31:0] XOR_S1     = 32'h00c3_3c00;
	localparam logic [1:0]  OKAY       = 2'b00;
	localparam logic [1:0]  DECERR     = 2'b11;
	localparam logic [2:0]  SIZE_M0    = 3'd2;
	localparam logic [2:0]  SIZE_M1    = 3'd1;
	localparam logic [1:0]  BURST_M0   = 2'b01;
	localparam logic [1:0]  BURST_M1   = 2'b00;

	logic        ACLK;
	logic        ARESETn;
	logic [3:0]  ARID_M0, ARID_M1;
	logic [31:0] ARADDR_M0, ARADDR_M1;
	logic [3:0]  ARLEN_M0, ARLEN_M1;
	logic [2:0]  ARSIZE_M0, ARSIZE_M1;
	logic [1:0]  ARBURST_M0, ARBURST_M1;
	logic        ARVALID_M0, ARVALID_M1;
	logic        ARREADY_M0, ARREADY_M1;
	logic [3:0]  RID_M0, RID_M1;
	logic [31:0] RDATA_M0, RDATA_M1;
	logic [1:0]  RRESP_M0, RRESP_M1;
	logic        RLAST_M0, RLAST_M1;
	logic        RVALID_M0, RVALID_M1;
	logic        RREADY_M0, RREADY_M1;
	logic [7:0]  ARID_S0, ARID_S1;
	logic [31:0] ARADDR_S0, ARADDR_S1;
	logic [3:0]  ARLEN_S0, ARLEN_S1;
	logic [2:0]  ARSIZE_S0, ARSIZE_S1;
	logic [1:0]  ARBURST_S0, ARBURST_S1;
	logic        ARVALID_S0, ARVALID_S1;
	logic        ARREADY_S0, ARREADY_S1;
	logic [7:0]  RID_S0, RID_S1;
	logic [31:0] RDATA_S0, RDATA_S1;
	logic [1:0]  RRESP_S0, RRESP_S1;
	logic        RLAST_S0, RLAST_S1;
	logic        RVALID_S0, RVALID_S1;
	logic        RREADY_S0, RREADY_S1;

	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          cycle_count = 0;
	logic [31:0] rng_state = 32'h47c6cab2;

	axi_read_xbar #(
		.S0_REGION (MAP_S0),
		.S1_REGION (MAP_S1)
	) uut (.*);

	axi_slave_model #(.DATA_XOR(XOR_S0)) s0_model (
		.ACLK    (ACLK),
		.arid    (ARID_S0),
		.araddr  (ARADDR_S0),
		.arlen   (ARLEN_S0),
		.arsize  (ARSIZE_S0),
		.arburst (ARBURST_S0),
		.arvalid (ARVALID_S0),
		.arready (ARREADY_S0),
		.rid     (RID_S0),
		.rdata   (RDATA_S0),
		.rresp   (RRESP_S0),
		.rlast   (RLAST_S0),
		.rvalid  (RVALID_S0),
		.rready  (RREADY_S0)
	);

	axi_slave_model #(.DATA_XOR(XOR_S1)) s1_model (
		.ACLK    (ACLK),
		.arid    (ARID_S1),
		.araddr  (ARADDR_S1),
		.arlen   (ARLEN_S1),
		.arsize  (ARSIZE_S1),
		.arburst (ARBURST_S1),
		.arvalid (ARVALID_S1),
		.arready (ARREADY_S1),
		.rid     (RID_S1),
		.rdata   (RDATA_S1),
		.rresp   (RRESP_S1),
		.rlast   (RLAST_S1),
		.rvalid  (RVALID_S1),
		.rready  (RREADY_S1)
	);

	initial begin
		ACLK = 1'b0;
		forever #(CLK_PERIOD / 2) ACLK = ~ACLK;
	end

	always @(posedge ACLK)
		cycle_count <= cycle_count + 1;

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift32();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic logic [31:0] expected_data(input logic [31:0] addr, input int k);
		logic [31:0] beat_addr;
		beat_addr = addr + 32'(4 * k);
		if (addr[31:16] == MAP_S0)
			return beat_addr ^ XOR_S0;
		else if (addr[31:16] == MAP_S1)
			return beat_addr ^ XOR_S1;
		return 32'h0; // Decode error beats carry no data.
	endfunction

	function automatic logic [1:0] expected_resp(input logic [31:0] addr);
		if (addr[31:16] == MAP_S0 || addr[31:16] == MAP_S1)
			return OKAY;
		return DECERR;
	endfunction

	function automatic logic arready_of(input int m);
		return (m == 0) ? ARREADY_M0 : ARREADY_M1;
	endfunction

	function automatic logic rvalid_of(input int m);
		return (m == 0) ? RVALID_M0 : RVALID_M1;
	endfunction

	function automatic logic rready_of(input int m);
		return (m == 0) ? RREADY_M0 : RREADY_M1;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic drive_ar(input int m, input logic valid, input logic [3:0] id,
			input logic [31:0] addr, input logic [3:0] len);
		if (m == 0) begin
			ARVALID_M0 = valid;
			ARID_M0    = id;
			ARADDR_M0  = addr;
			ARLEN_M0   = len;
		end else begin
			ARVALID_M1 = valid;
			ARID_M1    = id;
			ARADDR_M1  = addr;
			ARLEN_M1   = len;
		end
	endtask

	task automatic set_rready(input int m, input logic ready);
		if (m == 0)
			RREADY_M0 = ready;
		else
			RREADY_M1 = ready;
	endtask

	// Issues one burst and checks each beat against the slave rules.
	task automatic run_read(input int m, input logic [3:0] id, input logic [31:0] addr,
			input logic [3:0] len, input logic random_ready,
			output int ar_cycle, output int last_cycle);
		int          wait_cycles;
		int          k;
		logic        accepted;
		logic [31:0] rnd;
		ar_cycle    = -1;
		last_cycle  = -1;
		accepted    = 1'b0;
		wait_cycles = 0;
		k           = 0;
		@(negedge ACLK);
		drive_ar(m, 1'b1, id, addr, len);
		while (!accepted && wait_cycles < WAIT_LIMIT) begin
			@(posedge ACLK);
			if (arready_of(m)) begin
				accepted = 1'b1;
				ar_cycle = cycle_count;
			end else
				wait_cycles++;
		end
		@(negedge ACLK);
		drive_ar(m, 1'b0, 4'h0, 32'h0, 4'h0);
		if (!accepted) begin
			$display("Master %0d read at 0x%h was never accepted", m, addr);
			errors++;
		end else begin
			wait_cycles = 0;
			rnd = xorshift32();
			set_rready(m, !random_ready || rnd[0]);
			while (k <= int'(len) && wait_cycles < WAIT_LIMIT) begin
				@(posedge ACLK);
				check_value($sformatf("RVALID_M%0d", 1 - m), rvalid_of(1 - m), 1'b0);
				if (rvalid_of(m) && rready_of(m)) begin
					check_value($sformatf("RID_M%0d", m), (m == 0) ? RID_M0 : RID_M1, id);
					check_value($sformatf("RDATA_M%0d", m), (m == 0) ? RDATA_M0 : RDATA_M1,
						expected_data(addr, k));
					check_value($sformatf("RRESP_M%0d", m), (m == 0) ? RRESP_M0 : RRESP_M1,
						expected_resp(addr));
					check_value($sformatf("RLAST_M%0d", m), (m == 0) ? RLAST_M0 : RLAST_M1,
						k == int'(len));
					if (k == int'(len))
						last_cycle = cycle_count;
					k++;
					wait_cycles = 0;
				end else
					wait_cycles++;
				@(negedge ACLK);
				rnd = xorshift32();
				set_rready(m, (k <= int'(len)) && (!random_ready || rnd[0]));
			end
			if (k <= int'(len)) begin
				$display("Master %0d burst stopped after %0d of %0d beats", m, k, len + 1);
				errors++;
			end
			@(posedge ACLK);
			check_value($sformatf("RVALID_M%0d", m), rvalid_of(m), 1'b0); // Nothing after last.
		end
	endtask

	task automatic end_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start)
			$display("test %0d %s: ok", tests_run, name);
		else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - err_start);
		end
	endtask

	task automatic reset_outputs_low();
		int err_start;
		err_start = errors;
		@(posedge ACLK);
		check_value("ARREADY_M0", ARREADY_M0, 1'b0);
		check_value("ARREADY_M1", ARREADY_M1, 1'b0);
		check_value("ARVALID_S0", ARVALID_S0, 1'b0);
		check_value("ARVALID_S1", ARVALID_S1, 1'b0);
		check_value("RVALID_M0", RVALID_M0, 1'b0);
		check_value("RVALID_M1", RVALID_M1, 1'b0);
		end_test("reset state", err_start);
	endtask

	task automatic m0_read_from_s0();
		int err_start;
		int a;
		int l;
		err_start = errors;
		run_read(0, 4'h6, 32'h0000_0040, 4'd3, 1'b0, a, l);
		check_value("ARID_S0", s0_model.last_id, 8'h06);
		check_value("ARADDR_S0", s0_model.last_addr, 32'h0000_0040);
		check_value("ARSIZE_S0", s0_model.last_size, SIZE_M0);
		check_value("ARBURST_S0", s0_model.last_burst, BURST_M0);
		end_test("master 0 read from slave 0", err_start);
	endtask

	task automatic m1_read_with_stalls();
		int err_start;
		int a;
		int l;
		err_start = errors;
		run_read(1, 4'h5, 32'h0001_0100, 4'd7, 1'b1, a, l);
		check_value("ARID_S1", s1_model.last_id, 8'h15); // Master number above the ID.
		check_value("ARSIZE_S1", s1_model.last_size, SIZE_M1);
		check_value("ARBURST_S1", s1_model.last_burst, BURST_M1);
		end_test("master 1 read with RREADY stalls", err_start);
	endtask

	task automatic simultaneous_requests();
		int err_start;
		int a0;
		int l0;
		int a1;
		int l1;
		err_start = errors;
		fork
			run_read(0, 4'h2, 32'h0000_0200, 4'd3, 1'b0, a0, l0);
			run_read(1, 4'hb, 32'h0001_0300, 4'd2, 1'b0, a1, l1);
		join
		if (a0 < 0 || a1 <= a0 || a1 <= l0) begin
			$display("Master 1 accepted at cycle %0d, master 0 accepted at %0d, ended at %0d",
				a1, a0, l0);
			errors++;
		end
		end_test("simultaneous requests", err_start);
	endtask

	task automatic unmapped_read();
		int err_start;
		int s0_before;
		int s1_before;
		int a;
		int l;
		err_start = errors;
		s0_before = s0_model.valid_cycles;
		s1_before = s1_model.valid_cycles;
		run_read(0, 4'h9, 32'h00f0_0040, 4'd2, 1'b0, a, l);
		check_value("ARVALID_S0 cycles", s0_model.valid_cycles - s0_before, 0);
		check_value("ARVALID_S1 cycles", s1_model.valid_cycles - s1_before, 0);
		end_test("unmapped read", err_start);
	endtask

	task automatic random_reads();
		int          err_start;
		int          m;
		int          pick;
		int          a;
		int          l;
		logic [31:0] rnd;
		logic [15:0] region;
		logic [31:0] addr;
		err_start = errors;
		for (int i = 0; i < 20; i++) begin
			rnd    = xorshift32();
			m      = int'(rnd[0]);
			pick   = int'(rnd[9:4]) % 3;
			region = (pick == 0) ? MAP_S0 : (pick == 1) ? MAP_S1 : {1'b1, rnd[30:16]};
			rnd    = xorshift32();
			addr   = {region, rnd[15:2], 2'b00};
			run_read(m, rnd[19:16], addr, rnd[23:20], 1'b1, a, l);
		end
		end_test("random reads", err_start);
	endtask

	initial begin
		ARESETn    = 1'b0;
		ARSIZE_M0  = SIZE_M0;
		ARSIZE_M1  = SIZE_M1;
		ARBURST_M0 = BURST_M0;
		ARBURST_M1 = BURST_M1;
		RREADY_M0  = 1'b0;
		RREADY_M1  = 1'b0;
		drive_ar(0, 1'b0, 4'h0, 32'h0, 4'h0);
		drive_ar(1, 1'b0, 4'h0, 32'h0, 4'h0);
		repeat (2) @(posedge ACLK);
		@(negedge ACLK);
		ARESETn = 1'b1;
		reset_outputs_low();
		m0_read_from_s0();
		m1_read_with_stalls();
		simultaneous_requests();
		unmapped_read();
		random_reads();
		$display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: axi_read_xbar.f
hw/axi_pkg.sv
hw/xbar_pkg.sv
hw/axi_ar_if.sv
hw/axi_r_if.sv
hw/ar_arbiter.sv
hw/r_router.sv
hw/decerr_slave.sv
hw/axi_read_xbar.sv
tb/tb_axi_read_xbar.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_axi_read_xbar -f axi_read_xbar.f \
	&& ./obj_dir/Vtb_axi_read_xbar | tee /dev/stderr | grep -q "^TEST PASSED$" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
